//--- Makefile
VERILATOR  ?= verilator
TOP        := tb_prbs_checker
RTL_TOP    := prbs_checker_top
FILELIST   := list.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing -Wno-fatal
SIM_FLAGS  := --binary --timing -Wno-fatal
BIN        := $(OBJ_DIR)/V$(TOP)

.PHONY: lint sim build clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

sim: build
	@out="$$(./$(BIN) 2>&1)"; echo "$$out"; echo "$$out" | grep -q "TESTBENCH PASSED"

clean:
	rm -rf $(OBJ_DIR)

//--- list.f
prbs_pkg.sv
prbs_apb_pkg.sv
prbs_generator.sv
prbs_checker_core.sv
prbs_error_accum.sv
prbs_apb_regs.sv
prbs_checker_top.sv
tb_prbs_checker.sv

//--- prbs_apb_pkg.sv
package prbs_apb_pkg;

    localparam int apb_addr_width = 8;
    localparam int apb_data_width = 32;

    // register byte addresses
    localparam logic [apb_addr_width-1:0] addr_ctrl = 8'h00;
    localparam logic [apb_addr_width-1:0] addr_shift = 8'h04;
    localparam logic [apb_addr_width-1:0] addr_bit_cnt = 8'h08;
    localparam logic [apb_addr_width-1:0] addr_err_bits = 8'h0C;
    localparam logic [apb_addr_width-1:0] addr_err_words = 8'h10;
    localparam logic [apb_addr_width-1:0] addr_last = 8'h14;

    // one seed word per lane, 4 bytes apart
    localparam logic [apb_addr_width-1:0] addr_seed_base = 8'h40;

    // control register bits
    localparam int ctrl_prbs_en = 0;
    localparam int ctrl_count_en = 1;
    // write-one pulses, read back as zero
    localparam int ctrl_restart = 2;
    localparam int ctrl_clear = 3;

endpackage

//--- prbs_apb_regs.sv
`timescale 1ns/1ps

module prbs_apb_regs (
    input  logic                                    clk,
    input  logic                                    rst,
    input  logic                                    psel,
    input  logic                                    penable,
    input  logic                                    pwrite,
    input  logic [prbs_apb_pkg::apb_addr_width-1:0] paddr,
    input  logic [prbs_apb_pkg::apb_data_width-1:0] pwdata,
    output logic [prbs_apb_pkg::apb_data_width-1:0] prdata,
    output logic                                    pready,
    output logic                                    pslverr,
    input  logic [prbs_pkg::n_match_bits-1:0]       match_bits,
    input  logic                                    match,
    input  logic [prbs_pkg::cnt_width-1:0]          bit_cnt,
    input  logic [prbs_pkg::cnt_width-1:0]          err_bits,
    input  logic [prbs_pkg::cnt_width-1:0]          err_words,
    output logic                                    prbs_cke,
    output logic                                    acc_en,
    output logic                                    core_rst,
    output logic                                    acc_clear,
    output logic [prbs_pkg::n_shift_bits-1:0]       rx_shift,
    output logic [prbs_pkg::n_prbs-1:0]             seeds [prbs_pkg::n_channels]
);

    logic                                    access;
    logic                                    mapped;
    logic                                    wr_en;
    logic                                    ctrl_wr;
    logic                                    seed_hit;
    logic [prbs_apb_pkg::apb_addr_width-1:0] seed_off;
    logic [prbs_pkg::n_shift_bits-1:0]       seed_idx;
    logic [prbs_apb_pkg::apb_data_width-1:0] rdata;

    // zero-wait slave
    assign pready = 1'b1;
    assign access = psel && penable;

    // seed window, word aligned, one word per lane
    assign seed_off = paddr - prbs_apb_pkg::addr_seed_base;
    assign seed_hit = (paddr >= prbs_apb_pkg::addr_seed_base)
                   && (seed_off[1:0] == 2'b00)
                   && (seed_off[prbs_apb_pkg::apb_addr_width-1:2] < prbs_pkg::n_channels);
    // lane index is as wide as the shift field
    assign seed_idx = seed_off[2 +: prbs_pkg::n_shift_bits];

    // read mux, also tells which addresses are mapped
    always_comb begin
        mapped = 1'b1;
        rdata = '0;
        case (paddr)
            prbs_apb_pkg::addr_ctrl: begin
                rdata[prbs_apb_pkg::ctrl_prbs_en] = prbs_cke;
                rdata[prbs_apb_pkg::ctrl_count_en] = acc_en;
            end
            prbs_apb_pkg::addr_shift: rdata[prbs_pkg::n_shift_bits-1:0] = rx_shift;
            prbs_apb_pkg::addr_bit_cnt: rdata = bit_cnt;
            prbs_apb_pkg::addr_err_bits: rdata = err_bits;
            prbs_apb_pkg::addr_err_words: rdata = err_words;
            prbs_apb_pkg::addr_last: begin
                rdata[prbs_pkg::n_match_bits-1:0] = match_bits;
                rdata[8] = match;
            end
            default: begin
                if (seed_hit) begin
                    rdata[prbs_pkg::n_prbs-1:0] = seeds[seed_idx];
                end else begin
                    mapped = 1'b0;
                end
            end
        endcase
    end

    assign prdata = (access && !pwrite) ? rdata : '0;
    assign pslverr = access && !mapped;

    assign wr_en = access && pwrite && mapped;
    assign ctrl_wr = wr_en && (paddr == prbs_apb_pkg::addr_ctrl);

    always_ff @(posedge clk) begin
        if (rst) begin
            prbs_cke <= 1'b0;
            acc_en <= 1'b0;
            rx_shift <= '0;
            for (int i = 0; i < prbs_pkg::n_channels; i++) begin
                seeds[i] <= '0;
            end
        end else if (wr_en) begin
            if (paddr == prbs_apb_pkg::addr_ctrl) begin
                prbs_cke <= pwdata[prbs_apb_pkg::ctrl_prbs_en];
                acc_en <= pwdata[prbs_apb_pkg::ctrl_count_en];
            end
            if (paddr == prbs_apb_pkg::addr_shift) begin
                rx_shift <= pwdata[prbs_pkg::n_shift_bits-1:0];
            end
            if (seed_hit) begin
                seeds[seed_idx] <= pwdata[prbs_pkg::n_prbs-1:0];
            end
        end
    end

    // one-cycle pulses, also held during reset
    always_ff @(posedge clk) begin
        core_rst <= rst || (ctrl_wr && pwdata[prbs_apb_pkg::ctrl_restart]);
        acc_clear <= rst || (ctrl_wr && pwdata[prbs_apb_pkg::ctrl_clear]);
    end

endmodule

//--- prbs_checker_core.sv
`timescale 1ns/1ps

module prbs_checker_core (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              prbs_cke,
    input  logic [prbs_pkg::n_prbs-1:0]       prbs_init_vals [prbs_pkg::n_channels],
    input  logic [prbs_pkg::n_channels-1:0]   rx_bits,
    input  logic [prbs_pkg::n_shift_bits-1:0] rx_shift,
    output logic [prbs_pkg::n_match_bits-1:0] match_bits,
    output logic                              match
);

    // receive history, prev_1 is the newest word
    logic [prbs_pkg::n_channels-1:0]   rx_prev_1;
    logic [prbs_pkg::n_channels-1:0]   rx_prev_2;
    logic [2*prbs_pkg::n_channels-1:0] rx_concat;
    logic [prbs_pkg::n_channels-1:0]   window;
    logic [prbs_pkg::n_channels-1:0]   rx_select;
    logic [prbs_pkg::n_channels-1:0]   prbs_bits;
    logic [prbs_pkg::n_channels-1:0]   eq_bits;
    logic [prbs_pkg::n_match_bits-1:0] match_cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            rx_prev_1 <= '0;
            rx_prev_2 <= '0;
        end else begin
            rx_prev_1 <= rx_bits;
            rx_prev_2 <= rx_prev_1;
        end
    end

    // one local generator per lane
    for (genvar k = 0; k < prbs_pkg::n_channels; k++) begin : g_lane
        prbs_generator u_gen (
            .clk      (clk),
            .rst      (rst),
            .cke      (prbs_cke),
            .init_val (prbs_init_vals[k]),
            .out      (prbs_bits[k])
        );
    end

    // skew correction, shift 0 takes prev_1 as is
    assign rx_concat = {rx_prev_1, rx_prev_2};
    assign window = rx_concat[(2*prbs_pkg::n_channels-1-int'(rx_shift)) -: prbs_pkg::n_channels];

    always_ff @(posedge clk) begin
        if (rst) begin
            rx_select <= '0;
        end else begin
            rx_select <= window;
        end
    end

    // lane-by-lane compare against the local sequence
    assign eq_bits = rx_select ~^ prbs_bits;

    always_comb begin
        match_cnt = '0;
        for (int i = 0; i < prbs_pkg::n_channels; i++) begin
            match_cnt = match_cnt + {{(prbs_pkg::n_match_bits-1){1'b0}}, eq_bits[i]};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            match_bits <= '0;
            match <= 1'b0;
        end else begin
            match_bits <= match_cnt;
            // every lane agrees
            match <= &eq_bits;
        end
    end

endmodule

//--- prbs_checker_top.sv
`timescale 1ns/1ps

module prbs_checker_top (
    input  logic                                    clk,
    input  logic                                    rst,
    input  logic                                    psel,
    input  logic                                    penable,
    input  logic                                    pwrite,
    input  logic [prbs_apb_pkg::apb_addr_width-1:0] paddr,
    input  logic [prbs_apb_pkg::apb_data_width-1:0] pwdata,
    output logic [prbs_apb_pkg::apb_data_width-1:0] prdata,
    output logic                                    pready,
    output logic                                    pslverr,
    input  logic [prbs_pkg::n_channels-1:0]         rx_bits
);

    logic                              prbs_cke;
    logic                              acc_en;
    logic                              core_rst;
    logic                              acc_clear;
    logic [prbs_pkg::n_shift_bits-1:0] rx_shift;
    logic [prbs_pkg::n_prbs-1:0]       seeds [prbs_pkg::n_channels];
    logic [prbs_pkg::n_match_bits-1:0] match_bits;
    logic                              match;
    logic [prbs_pkg::cnt_width-1:0]    bit_cnt;
    logic [prbs_pkg::cnt_width-1:0]    err_bits;
    logic [prbs_pkg::cnt_width-1:0]    err_words;

    prbs_apb_regs u_regs (
        .clk        (clk),
        .rst        (rst),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .match_bits (match_bits),
        .match      (match),
        .bit_cnt    (bit_cnt),
        .err_bits   (err_bits),
        .err_words  (err_words),
        .prbs_cke   (prbs_cke),
        .acc_en     (acc_en),
        .core_rst   (core_rst),
        .acc_clear  (acc_clear),
        .rx_shift   (rx_shift),
        .seeds      (seeds)
    );

    // restart reloads the generators through the core reset
    prbs_checker_core u_core (
        .clk            (clk),
        .rst            (core_rst),
        .prbs_cke       (prbs_cke),
        .prbs_init_vals (seeds),
        .rx_bits        (rx_bits),
        .rx_shift       (rx_shift),
        .match_bits     (match_bits),
        .match          (match)
    );

    prbs_error_accum u_accum (
        .clk        (clk),
        .rst        (rst),
        .clear      (acc_clear),
        .en         (acc_en),
        .match      (match),
        .match_bits (match_bits),
        .bit_cnt    (bit_cnt),
        .err_bits   (err_bits),
        .err_words  (err_words)
    );

endmodule

//--- prbs_error_accum.sv
`timescale 1ns/1ps

module prbs_error_accum (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              clear,
    input  logic                              en,
    input  logic                              match,
    input  logic [prbs_pkg::n_match_bits-1:0] match_bits,
    output logic [prbs_pkg::cnt_width-1:0]    bit_cnt,
    output logic [prbs_pkg::cnt_width-1:0]    err_bits,
    output logic [prbs_pkg::cnt_width-1:0]    err_words
);

    // lanes that disagreed in this word
    logic [prbs_pkg::n_match_bits-1:0] miss_bits;

    // sums one bit wider so the carry shows an overflow
    logic [prbs_pkg::cnt_width:0] bit_cnt_sum;
    logic [prbs_pkg::cnt_width:0] err_bits_sum;
    logic [prbs_pkg::cnt_width:0] err_words_sum;

    assign miss_bits = prbs_pkg::n_match_bits'(prbs_pkg::n_channels) - match_bits;

    assign bit_cnt_sum = {1'b0, bit_cnt} + (prbs_pkg::cnt_width+1)'(prbs_pkg::n_channels);
    assign err_bits_sum = {1'b0, err_bits} + (prbs_pkg::cnt_width+1)'(miss_bits);
    assign err_words_sum = {1'b0, err_words} + (prbs_pkg::cnt_width+1)'(!match);

    always_ff @(posedge clk) begin
        if (rst || clear) begin
            bit_cnt <= '0;
            err_bits <= '0;
            err_words <= '0;
        end else if (en) begin
            // each counter sticks at all ones once it overflows
            if (bit_cnt_sum[prbs_pkg::cnt_width]) begin
                bit_cnt <= '1;
            end else begin
                bit_cnt <= bit_cnt_sum[prbs_pkg::cnt_width-1:0];
            end

            if (err_bits_sum[prbs_pkg::cnt_width]) begin
                err_bits <= '1;
            end else begin
                err_bits <= err_bits_sum[prbs_pkg::cnt_width-1:0];
            end

            if (err_words_sum[prbs_pkg::cnt_width]) begin
                err_words <= '1;
            end else begin
                err_words <= err_words_sum[prbs_pkg::cnt_width-1:0];
            end
        end
    end

endmodule

//--- prbs_generator.sv
`timescale 1ns/1ps

module prbs_generator (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        cke,
    input  logic [prbs_pkg::n_prbs-1:0] init_val,
    output logic                        out
);

    // Fibonacci LFSR state, msb is the output bit
    logic [prbs_pkg::n_prbs-1:0] lfsr;
    logic                        feedback;

    assign feedback = lfsr[prbs_pkg::prbs_tap_hi] ^ lfsr[prbs_pkg::prbs_tap_lo];

    always_ff @(posedge clk) begin
        if (rst) begin
            // reload the seed, a zero seed locks the register at zero
            lfsr <= init_val;
        end else if (cke) begin
            lfsr <= {lfsr[prbs_pkg::n_prbs-2:0], feedback};
        end
    end

    assign out = lfsr[prbs_pkg::n_prbs-1];

endmodule

//--- prbs_pkg.sv
package prbs_pkg;

    // PRBS7 register length
    localparam int n_prbs = 7;

    // number of receive lanes, each with its own generator
    localparam int n_channels = 16;

    // lane shift width, enough to index any lane of the window
    localparam int n_shift_bits = 4;

    // match count runs from 0 to n_channels inclusive
    localparam int n_match_bits = 5;

    // feedback taps for x^7 + x^6 + 1
    localparam int prbs_tap_hi = 6;
    localparam int prbs_tap_lo = 5;

    // width of the BER statistics counters
    localparam int cnt_width = 32;

endpackage

//--- tb_prbs_checker.sv
`timescale 1ns/1ps

module tb_prbs_checker;

    logic                                    clk;
    logic                                    rst;
    logic                                    psel;
    logic                                    penable;
    logic                                    pwrite;
    logic [prbs_apb_pkg::apb_addr_width-1:0] paddr;
    logic [prbs_apb_pkg::apb_data_width-1:0] pwdata;
    logic [prbs_apb_pkg::apb_data_width-1:0] prdata;
    logic                                    pready;
    logic                                    pslverr;
    logic [prbs_pkg::n_channels-1:0]         rx_bits;

    integer stim_seed;
    integer rx_seed;

    // rx_mode selects idle (0), transmitter stream (1) or random words (2)
    int       rx_mode = 0;
    bit       inject = 0;
    logic [3:0] skew = '0;
    int       cur_flip_cnt = 0;

    // model state
    logic [6:0]  m_lfsr [16];
    logic [6:0]  m_seeds [16];
    logic [15:0] m_prev1;
    logic [15:0] m_prev2;
    logic [15:0] m_sel;
    logic [4:0]  m_mbits;
    logic        m_match;
    logic        m_cke;
    logic        m_acc_en;
    logic        m_core_rst;
    logic        m_acc_clear;
    logic [3:0]  m_shift;
    logic [31:0] m_bit_cnt;
    logic [31:0] m_err_bits;
    logic [31:0] m_err_words;

    // reference counts for the aligned and injected streams
    int ref_words;
    int ref_inj_bits;
    int ref_inj_words;
    int flip_p1;
    int flip_p2;
    int flip_p3;

    prbs_checker_top u_dut (
        .clk     (clk),
        .rst     (rst),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .rx_bits (rx_bits)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // x^7 + x^6 + 1 shifts left and feeds bit 6 xor bit 5 into bit 0
    function automatic logic [6:0] lfsr_next(input logic [6:0] s);
        return {s[5:0], s[6] ^ s[5]};
    endfunction

    function automatic logic [31:0] sat_add(input logic [31:0] a, input logic [31:0] b);
        logic [32:0] s;
        s = {1'b0, a} + {1'b0, b};
        return s[32] ? 32'hffff_ffff : s[31:0];
    endfunction

    function automatic logic [31:0] ctrl_word(input bit en, input bit cnt, input bit rs, input bit cl);
        logic [31:0] w;
        w = '0;
        w[prbs_apb_pkg::ctrl_prbs_en] = en;
        w[prbs_apb_pkg::ctrl_count_en] = cnt;
        w[prbs_apb_pkg::ctrl_restart] = rs;
        w[prbs_apb_pkg::ctrl_clear] = cl;
        return w;
    endfunction

    function automatic bit addr_mapped(input logic [7:0] addr);
        logic [7:0] off;
        off = addr - prbs_apb_pkg::addr_seed_base;
        case (addr)
            prbs_apb_pkg::addr_ctrl, prbs_apb_pkg::addr_shift, prbs_apb_pkg::addr_bit_cnt,
            prbs_apb_pkg::addr_err_bits, prbs_apb_pkg::addr_err_words,
            prbs_apb_pkg::addr_last: return 1'b1;
            default: return (addr >= prbs_apb_pkg::addr_seed_base) && (off[1:0] == 2'b00)
                         && (off[7:2] < 6'd16);
        endcase
    endfunction

    function automatic logic [31:0] model_read(input logic [7:0] addr);
        logic [31:0] r;
        logic [7:0]  off;
        r = '0;
        off = addr - prbs_apb_pkg::addr_seed_base;
        case (addr)
            prbs_apb_pkg::addr_ctrl: begin
                r[prbs_apb_pkg::ctrl_prbs_en] = m_cke;
                r[prbs_apb_pkg::ctrl_count_en] = m_acc_en;
            end
            prbs_apb_pkg::addr_shift: r[3:0] = m_shift;
            prbs_apb_pkg::addr_bit_cnt: r = m_bit_cnt;
            prbs_apb_pkg::addr_err_bits: r = m_err_bits;
            prbs_apb_pkg::addr_err_words: r = m_err_words;
            prbs_apb_pkg::addr_last: begin
                r[4:0] = m_mbits;
                r[8] = m_match;
            end
            default: if (addr_mapped(addr)) r[6:0] = m_seeds[off[5:2]];
        endcase
        return r;
    endfunction

    // transmitter word a given number of steps ahead of the local generators
    function automatic logic [15:0] tx_word(input int steps);
        logic [15:0] w;
        logic [6:0]  s;
        for (int k = 0; k < 16; k++) begin
            s = m_lfsr[k];
            for (int i = 0; i < steps; i++) s = lfsr_next(s);
            w[k] = s[6];
        end
        return w;
    endfunction

    task automatic check_equal(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
            $display("TESTBENCH FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // one zero-wait transfer with setup and access cycles, checked against the model
    task automatic apb_access(input bit wr, input logic [7:0] addr, input logic [31:0] data,
                              output logic [31:0] rdata);
        int n;
        @(negedge clk);
        psel = 1'b1;
        penable = 1'b0;
        pwrite = wr;
        paddr = addr;
        pwdata = data;
        @(negedge clk);
        penable = 1'b1;
        n = 0;
        while (pready !== 1'b1) begin
            if (n == 8) begin
                $display("APB transfer to address %h never saw pready", addr);
                $display("TESTBENCH FAILED");
                $fatal(1, "pready timeout");
            end else begin
                @(negedge clk);
                n++;
            end
        end
        #1;
        check_equal(pslverr, !addr_mapped(addr), "pslverr");
        if (!wr) check_equal(prdata, model_read(addr), "read data");
        rdata = prdata;
        @(negedge clk);
        psel = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
        logic [31:0] unused;
        apb_access(1'b1, addr, data, unused);
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
        apb_access(1'b0, addr, '0, data);
    endtask

    task automatic set_rx(input int mode, input logic [3:0] sk, input bit inj);
        @(posedge clk);
        rx_mode = mode;
        skew = sk;
        inject = inj;
    endtask

    task automatic run_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    always @(negedge clk) begin : rx_drive
        logic [31:0] both;
        logic [15:0] mask;
        int          n;
        mask = '0;
        n = 0;
        if (rx_mode == 1) begin
            // skewed lanes take the next transmitter word
            both = {tx_word(3), tx_word(2)} >> skew;
            if (inject && (($random(rx_seed) & 3) == 0)) mask = 16'($random(rx_seed));
            rx_bits = both[15:0] ^ mask;
        end else if (rx_mode == 2) begin
            rx_bits = 16'($random(rx_seed));
        end else begin
            rx_bits = '0;
        end
        for (int k = 0; k < 16; k++) n += mask[k];
        cur_flip_cnt = n;
    end

    // stages stepped from the accumulator back to the registers
    always @(posedge clk) begin : model_step
        logic [31:0] join_w;
        int          cnt;
        bit          wr;
        if (rst || m_acc_clear) begin
            m_bit_cnt = '0;
            m_err_bits = '0;
            m_err_words = '0;
            ref_words = 0;
            ref_inj_bits = 0;
            ref_inj_words = 0;
        end else if (m_acc_en) begin
            m_bit_cnt = sat_add(m_bit_cnt, 32'd16);
            m_err_bits = sat_add(m_err_bits, 32'(16 - m_mbits));
            m_err_words = sat_add(m_err_words, 32'(!m_match));
            ref_words++;
            ref_inj_bits += flip_p3;
            ref_inj_words += (flip_p3 != 0);
        end
        flip_p3 = flip_p2;
        flip_p2 = flip_p1;
        flip_p1 = cur_flip_cnt;

        if (m_core_rst) begin
            m_prev1 = '0;
            m_prev2 = '0;
            m_sel = '0;
            m_mbits = '0;
            m_match = 1'b0;
            for (int k = 0; k < 16; k++) m_lfsr[k] = m_seeds[k];
        end else begin
            cnt = 0;
            for (int k = 0; k < 16; k++) cnt += (m_sel[k] == m_lfsr[k][6]);
            m_mbits = 5'(cnt);
            m_match = (cnt == 16);
            join_w = {m_prev1, m_prev2};
            m_sel = 16'(join_w >> (16 - m_shift));
            m_prev2 = m_prev1;
            m_prev1 = rx_bits;
            if (m_cke) begin
                for (int k = 0; k < 16; k++) m_lfsr[k] = lfsr_next(m_lfsr[k]);
            end
        end

        wr = psel && penable && pwrite && addr_mapped(paddr);
        m_core_rst = rst || (wr && paddr == prbs_apb_pkg::addr_ctrl
                             && pwdata[prbs_apb_pkg::ctrl_restart]);
        m_acc_clear = rst || (wr && paddr == prbs_apb_pkg::addr_ctrl
                              && pwdata[prbs_apb_pkg::ctrl_clear]);
        if (rst) begin
            m_cke = 1'b0;
            m_acc_en = 1'b0;
            m_shift = '0;
            for (int k = 0; k < 16; k++) m_seeds[k] = '0;
        end else if (wr) begin
            if (paddr == prbs_apb_pkg::addr_ctrl) begin
                m_cke = pwdata[prbs_apb_pkg::ctrl_prbs_en];
                m_acc_en = pwdata[prbs_apb_pkg::ctrl_count_en];
            end
            if (paddr == prbs_apb_pkg::addr_shift) m_shift = pwdata[3:0];
            if (paddr >= prbs_apb_pkg::addr_seed_base) m_seeds[paddr[5:2]] = pwdata[6:0];
        end
    end

    initial begin : watchdog
        repeat (50000) @(posedge clk);
        $display("simulation ran too long without finishing the test sequence");
        $display("TESTBENCH FAILED");
        $fatal(1, "global timeout");
    end

    initial begin : stimulus
        logic [31:0] rd;
        logic [31:0] held;
        logic [31:0] r;
        logic [7:0]  addr;
        logic [3:0]  sk;
        stim_seed = 32'h9871_ba4c;
        rx_seed = ~stim_seed;
        rst = 1'b1;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        rx_bits = '0;
        repeat (5) @(negedge clk);
        rst = 1'b0;

        // aligned stream
        for (int k = 0; k < 16; k++) apb_write(8'h40 + 8'(4 * k), $random(stim_seed));
        apb_write(prbs_apb_pkg::addr_shift, 32'd0);
        set_rx(1, 4'd0, 1'b0);
        apb_write(prbs_apb_pkg::addr_ctrl, ctrl_word(1, 0, 1, 0));
        run_cycles(8);
        apb_write(prbs_apb_pkg::addr_ctrl, ctrl_word(1, 1, 0, 1));
        run_cycles(40 + ($random(stim_seed) & 63));
        // counting stops so the totals hold still while they are read
        apb_write(prbs_apb_pkg::addr_ctrl, ctrl_word(1, 0, 0, 0));
        apb_read(prbs_apb_pkg::addr_last, rd);
        check_equal(rd[8], 1'b1, "aligned match flag");
        apb_read(prbs_apb_pkg::addr_err_bits, rd);
        check_equal(rd, 32'd0, "aligned err_bits");
        apb_read(prbs_apb_pkg::addr_err_words, rd);
        check_equal(rd, 32'd0, "aligned err_words");
        apb_read(prbs_apb_pkg::addr_bit_cnt, rd);
        check_equal(rd, 32'(16 * ref_words), "aligned bit_cnt");
        for (int k = 0; k < 16; k++) apb_read(8'h40 + 8'(4 * k), rd);

        // injected errors drain out of the pipeline before the counters are read
        apb_write(prbs_apb_pkg::addr_ctrl, ctrl_word(1, 1, 0, 0));
        set_rx(1, 4'd0, 1'b1);
        run_cycles(200);
        set_rx(1, 4'd0, 1'b0);
        run_cycles(6);
        apb_read(prbs_apb_pkg::addr_err_bits, rd);
        check_equal(rd, 32'(ref_inj_bits), "injected err_bits");
        apb_read(prbs_apb_pkg::addr_err_words, rd);
        check_equal(rd, 32'(ref_inj_words), "injected err_words");
        check_equal(32'(ref_inj_words > 0), 32'd1, "words with injected errors");

        // lane skew
        repeat (6) begin
            sk = 4'($random(stim_seed));
            apb_write(prbs_apb_pkg::addr_shift, 32'(sk));
            set_rx(1, sk, 1'b0);
            run_cycles(8);
            apb_read(prbs_apb_pkg::addr_last, rd);
            check_equal(rd[8], 1'b1, "skewed match flag");
        end

        // random data
        set_rx(2, skew, 1'b0);
        repeat (10) begin
            run_cycles(1 + ($random(stim_seed) & 15));
            apb_read(prbs_apb_pkg::addr_last, rd);
            apb_read(prbs_apb_pkg::addr_bit_cnt, rd);
            apb_read(prbs_apb_pkg::addr_err_bits, rd);
            apb_read(prbs_apb_pkg::addr_err_words, rd);
        end

        // clear with counting off
        apb_write(prbs_apb_pkg::addr_ctrl, ctrl_word(1, 0, 0, 1));
        run_cycles(2);
        apb_read(prbs_apb_pkg::addr_bit_cnt, rd);
        check_equal(rd, 32'd0, "cleared bit_cnt");
        apb_read(prbs_apb_pkg::addr_err_bits, rd);
        check_equal(rd, 32'd0, "cleared err_bits");
        apb_read(prbs_apb_pkg::addr_err_words, rd);
        check_equal(rd, 32'd0, "cleared err_words");

        // counters frozen while count enable is low
        apb_write(prbs_apb_pkg::addr_ctrl, ctrl_word(1, 1, 0, 0));
        run_cycles(20);
        apb_write(prbs_apb_pkg::addr_ctrl, ctrl_word(1, 0, 0, 0));
        held = 32'(16 * ref_words);
        run_cycles(20);
        apb_read(prbs_apb_pkg::addr_bit_cnt, rd);
        check_equal(rd, held, "frozen bit_cnt");
        apb_read(prbs_apb_pkg::addr_err_bits, rd);
        apb_read(prbs_apb_pkg::addr_err_words, rd);

        // generators hold with prbs enable low
        apb_write(prbs_apb_pkg::addr_ctrl, ctrl_word(0, 1, 0, 0));
        set_rx(1, skew, 1'b0);
        repeat (5) begin
            run_cycles(4 + ($random(stim_seed) & 7));
            apb_read(prbs_apb_pkg::addr_last, rd);
            apb_read(prbs_apb_pkg::addr_err_bits, rd);
        end

        // unmapped addresses flag pslverr and leave the state alone
        repeat (8) begin
            r = $random(stim_seed);
            addr = r[8] ? (8'h80 | {1'b0, r[6:0]}) : (8'h18 + 8'(r[15:0] % 40));
            apb_write(addr, $random(stim_seed));
            apb_read(addr, rd);
        end
        apb_read(prbs_apb_pkg::addr_ctrl, rd);
        apb_read(prbs_apb_pkg::addr_shift, rd);
        for (int k = 0; k < 16; k++) apb_read(8'h40 + 8'(4 * k), rd);
        apb_write(prbs_apb_pkg::addr_ctrl, $random(stim_seed));
        apb_read(prbs_apb_pkg::addr_ctrl, rd);
        check_equal(rd >> 2, 32'd0, "control upper bits");

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule
